// ==== src/dmem_pkg.sv ====
// shared definitions for the data memory subsystem.
// holds the load and store opcode enum, the response record,
// the word and lane constants and the opcode size and sign helpers.
package dmem_pkg;

    localparam int DATA_WIDTH   = 32;             // width of one memory word.
    localparam int BYTE_LANES   = DATA_WIDTH / 8; // byte lanes in one word.
    localparam int OP_STORE_BIT = 3;              // opcode bit that marks a store.

    // bit 3 marks a store, bit 2 marks an unsigned load, bits 1:0 give the size code.
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } mem_op_t;

    // one response as seen by the requester.
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
        logic                  err;
    } dmem_rsp_t;

    // number of bytes moved by an access.
    function automatic logic [2:0] op_size(mem_op_t op);
        case (op)
            LB, LBU, SB: return 3'd1;
            LH, LHU, SH: return 3'd2;
            default:     return 3'd4; // LW and SW move a whole word.
        endcase
    endfunction

    // only the signed byte and halfword loads extend the top bit.
    function automatic logic op_signed(mem_op_t op);
        return (op == LB) || (op == LH);
    endfunction

    function automatic logic op_is_store(mem_op_t op);
        return op[OP_STORE_BIT];
    endfunction

endpackage

// ==== src/dmem_req_if.sv ====
// one aligned memory access travelling from the aligner to the RAM and the
// load extractor, with source, RAM sink and response tag modports.
`timescale 1ns/1ps

interface dmem_req_if
    import dmem_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
);

    logic                  valid;    // an access is being performed this cycle.
    mem_op_t               op;       // opcode of the access.
    logic [ADDR_WIDTH-1:0] waddr;    // word address into the RAM.
    logic                  we;       // gated write enable, already checked for alignment.
    logic [BYTE_LANES-1:0] wmask;    // byte lanes touched by the access.
    logic [DATA_WIDTH-1:0] wdata;    // store data placed in its lanes.
    logic [1:0]            offset;   // byte offset within the word.
    logic                  misalign; // the address does not fit the access size.

    // the aligner drives every field.
    modport source (output valid, op, waddr, we, wmask, wdata, offset, misalign);

    // the RAM only needs what moves data in and out of the array.
    modport sink (input waddr, we, wmask, wdata);

    // the load extractor keeps the fields that shape the response.
    modport tag (input valid, op, offset, misalign);

endinterface

// ==== src/req_queue.sv ====
// circular request buffer between the requester and the RAM pipeline.
// the head entry leaves on every cycle the buffer is occupied, and each
// departure hands one credit back to the requester.
`timescale 1ns/1ps

module req_queue
    import dmem_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_WIDTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,          // requester hands over one request.
    input  mem_op_t               push_op,
    input  logic [ADDR_WIDTH+1:0] push_addr,     // byte address.
    input  logic [DATA_WIDTH-1:0] push_wdata,
    output logic                  pop_valid,     // head entry is presented and taken.
    output mem_op_t               pop_op,
    output logic [ADDR_WIDTH+1:0] pop_addr,
    output logic [DATA_WIDTH-1:0] pop_wdata,
    output logic                  credit_return  // one pulse per popped entry.
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mem_op_t               op_q   [QUEUE_DEPTH]; // entry storage, one slot per credit.
    logic [ADDR_WIDTH+1:0] addr_q [QUEUE_DEPTH];
    logic [DATA_WIDTH-1:0] data_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr; // next free slot.
    logic [PTR_W-1:0] rd_ptr; // current head slot.
    logic [CNT_W-1:0] count;  // entries held.

    // pointers wrap at the depth, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_valid     = (count != '0);  // never stalls, so occupied means popping.
    assign pop_op        = op_q[rd_ptr];
    assign pop_addr      = addr_q[rd_ptr];
    assign pop_wdata     = data_q[rd_ptr];
    assign credit_return = pop_valid;      // the credit goes back in the cycle of the pop.

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]   <= push_op;
            addr_q[wr_ptr] <= push_addr;
            data_q[wr_ptr] <= push_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop_valid) rd_ptr <= next_ptr(rd_ptr);
            // a push and a pop in the same cycle leave the count unchanged.
            case ({push, pop_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/access_align.sv ====
// combinational decode of a popped request into one RAM access.
// checks natural alignment, builds the byte mask, places store data in
// its lanes and forms the word address and the gated write enable.
`timescale 1ns/1ps

module access_align
    import dmem_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  pop_valid,
    input  mem_op_t               pop_op,
    input  logic [ADDR_WIDTH+1:0] pop_addr,  // byte address.
    input  logic [DATA_WIDTH-1:0] pop_wdata,
    dmem_req_if.source            acc
);

    logic [1:0] offset;    // byte within the word.
    logic [2:0] size;      // bytes moved by this opcode.
    logic       misalign;

    assign offset = pop_addr[1:0];
    assign size   = op_size(pop_op);

    // halfwords need an even address and words a multiple of four.
    always_comb begin
        case (size)
            3'd2:    misalign = offset[0];
            3'd4:    misalign = (offset != 2'b00);
            default: misalign = 1'b0; // a byte fits anywhere.
        endcase
    end

    always_comb begin
        case (size)
            3'd1: begin
                acc.wmask = 4'b0001 << offset;         // a single lane.
                acc.wdata = {4{pop_wdata[7:0]}};       // the byte sits in every lane.
            end
            3'd2: begin
                acc.wmask = 4'b0011 << offset;         // lanes 1:0 or 3:2.
                acc.wdata = {2{pop_wdata[15:0]}};      // copy the halfword into both halves.
            end
            default: begin
                acc.wmask = 4'b1111;
                acc.wdata = pop_wdata;
            end
        endcase
    end

    assign acc.valid    = pop_valid;
    assign acc.op       = pop_op;
    assign acc.waddr    = pop_addr[ADDR_WIDTH+1:2]; // drop the byte offset.
    assign acc.offset   = offset;
    assign acc.misalign = misalign;

    // the only place where writes are qualified.
    assign acc.we = pop_valid && op_is_store(pop_op) && !misalign;

endmodule

// ==== src/bram.sv ====
// single-port synchronous block RAM with a per-byte write mask.
// a read in the same cycle as a write to the same word sees the old word.
`timescale 1ns/1ps

module bram
    import dmem_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    dmem_req_if.sink              mem,
    output logic [DATA_WIDTH-1:0] rdata   // registered word at the last address.
);

    localparam int WORDS = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] ram [WORDS]; // the storage array.

    always_ff @(posedge clk) begin
        // each enabled lane is written on its own, the others keep their bytes.
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (mem.we && mem.wmask[i]) begin
                ram[mem.waddr][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
        end
        rdata <= ram[mem.waddr]; // nonblocking read returns the word before the write.
    end

endmodule

// ==== src/load_extract.sv ====
// response stage behind the RAM.
// registers the access tag, then selects the addressed bytes of the RAM
// word, extends them by the opcode sign rule and flags misaligned accesses.
`timescale 1ns/1ps

module load_extract
    import dmem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    dmem_req_if.tag               tag,
    input  logic [DATA_WIDTH-1:0] rdata,    // RAM word for the registered access.
    output logic                  rsp_valid,
    output logic [DATA_WIDTH-1:0] rsp_data,
    output logic                  rsp_err
);

    logic                  valid_q;    // an access was performed last cycle.
    mem_op_t               op_q;
    logic [1:0]            offset_q;
    logic                  misalign_q;
    logic [DATA_WIDTH-1:0] shifted;    // addressed bytes moved down to lane 0.
    logic [DATA_WIDTH-1:0] extended;   // load value after sign or zero extension.
    dmem_rsp_t             rsp;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= tag.valid;
        end
    end

    // the tag fields only matter while valid_q is set.
    always_ff @(posedge clk) begin
        op_q       <= tag.op;
        offset_q   <= tag.offset;
        misalign_q <= tag.misalign;
    end

    assign shifted = rdata >> {offset_q, 3'b000}; // eight bits per byte of offset.

    always_comb begin
        case (op_size(op_q))
            3'd1:    extended = {{24{op_signed(op_q) & shifted[7]}}, shifted[7:0]};
            3'd2:    extended = {{16{op_signed(op_q) & shifted[15]}}, shifted[15:0]};
            default: extended = shifted;
        endcase
    end

    always_comb begin
        rsp.valid = valid_q;
        rsp.err   = valid_q && misalign_q;
        // stores and errors answer with zero data.
        rsp.data  = (valid_q && !misalign_q && !op_is_store(op_q)) ? extended : '0;
    end

    assign rsp_valid = rsp.valid;
    assign rsp_data  = rsp.data;
    assign rsp_err   = rsp.err;

endmodule

// ==== src/dmem_subsys.sv ====
// top level of the data memory subsystem.
// connects the request queue, the aligner, the block RAM and the load
// extractor, and exposes plain request, credit and response ports.
`timescale 1ns/1ps

module dmem_subsys
    import dmem_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_WIDTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,     // only raised while a credit is held.
    input  mem_op_t               req_op,
    input  logic [ADDR_WIDTH+1:0] req_addr,      // byte address.
    input  logic [DATA_WIDTH-1:0] req_wdata,
    output logic                  credit_return,
    output logic                  rsp_valid,
    output logic [DATA_WIDTH-1:0] rsp_data,
    output logic                  rsp_err
);

    logic                  pop_valid;  // raw head request from the queue.
    mem_op_t               pop_op;
    logic [ADDR_WIDTH+1:0] pop_addr;
    logic [DATA_WIDTH-1:0] pop_wdata;
    logic [DATA_WIDTH-1:0] rdata;      // registered RAM word.

    dmem_req_if #(.ADDR_WIDTH(ADDR_WIDTH)) acc_if (); // the aligned access.

    req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (req_valid),
        .push_op       (req_op),
        .push_addr     (req_addr),
        .push_wdata    (req_wdata),
        .pop_valid     (pop_valid),
        .pop_op        (pop_op),
        .pop_addr      (pop_addr),
        .pop_wdata     (pop_wdata),
        .credit_return (credit_return)
    );

    access_align #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_align (
        .pop_valid (pop_valid),
        .pop_op    (pop_op),
        .pop_addr  (pop_addr),
        .pop_wdata (pop_wdata),
        .acc       (acc_if.source)
    );

    bram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .mem   (acc_if.sink),
        .rdata (rdata)
    );

    load_extract u_extract (
        .clk       (clk),
        .rst       (rst),
        .tag       (acc_if.tag),
        .rdata     (rdata),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

endmodule

// ==== test/dmem_subsys_chk.sv ====
// concurrent assertions on the request queue, bound into req_queue.
// covers pushes into a full buffer, credits from an empty one, the
// occupancy bound and an unknown pop_valid after reset.
`timescale 1ns/1ps

module dmem_subsys_chk #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CNT_W       = 3
) (
    input logic             clk,
    input logic             rst,
    input logic             push,
    input logic             pop_valid,
    input logic             credit_return,
    input logic [CNT_W-1:0] count           // occupancy of the buffer.
);

    logic [CNT_W-1:0] held; // requests pushed and not yet answered by a credit.

    // shadow occupancy kept from the queue's own ports, apart from its counter.
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else begin
            held <= held + CNT_W'(push) - CNT_W'(credit_return);
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count < CNT_W'(QUEUE_DEPTH))) else $error("push into a full request queue");

    // a credit can only come back for an entry that is really there.
    no_empty_credit: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> (held != '0)) else $error("credit returned from an empty queue");

    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(QUEUE_DEPTH)) else $error("queue occupancy above its depth");

    pop_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(pop_valid)) else $error("pop_valid is unknown");

endmodule

bind req_queue dmem_subsys_chk #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CNT_W       (CNT_W)
) u_chk (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .pop_valid     (pop_valid),
    .credit_return (credit_return),
    .count         (count)
);

// ==== test/tb_dmem_subsys.sv ====
// testbench for the data memory subsystem.
// reads request vectors from the test data file, sends them under the
// credit rule with random idle gaps and checks every response in order.
`timescale 1ns/1ps

module tb_dmem_subsys
    import dmem_pkg::*;
();

    localparam int QUEUE_DEPTH = 4;   // same as the DUT defaults.
    localparam int ADDR_WIDTH  = 8;
    localparam int NUM_VEC     = 25;  // vectors in the data file.
    localparam int FIELDS      = 6;   // id, op, address, wdata, data, err.
    localparam int MAX_WAIT    = 200; // cycles allowed for any single wait.

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    mem_op_t               req_op;
    logic [ADDR_WIDTH+1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic                  credit_return;
    logic                  rsp_valid;
    logic [DATA_WIDTH-1:0] rsp_data;
    logic                  rsp_err;

    logic [31:0] vec_mem [NUM_VEC*FIELDS]; // flat vector store, FIELDS words each.
    logic [31:0] exp_id_q [$];             // expected responses, oldest first.
    logic [31:0] exp_data_q [$];
    logic        exp_err_q [$];
    int          push_edge_q [$];          // edge that accepted each request.

    int cycle_cnt    = 0; // rising edges since time zero.
    int pushes       = 0;
    int credits_back = 0;
    int responses    = 0;
    int checks       = 0;
    int drv_errors   = 0;
    int mon_errors   = 0;
    bit any_pushed   = 1'b0;
    bit aborted      = 1'b0;
    logic [31:0] seed = 32'd21102;

    dmem_subsys #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_err       (rsp_err)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // credits the requester holds right now.
    function automatic int credits_left();
        return QUEUE_DEPTH - pushes + credits_back;
    endfunction

    task automatic check_response();
        logic [31:0] id;
        logic [31:0] exp_data;
        logic        exp_err;
        int          accept_edge;
        if (exp_id_q.size() == 0) begin
            $display("response at cycle %0d with no request outstanding", cycle_cnt);
            mon_errors++;
        end else begin
            id          = exp_id_q.pop_front();
            exp_data    = exp_data_q.pop_front();
            exp_err     = exp_err_q.pop_front();
            accept_edge = push_edge_q.pop_front();
            checks++;
            if (rsp_data !== exp_data) begin
                $display("ERROR test %0h: rsp_data expected %h actual %h", id, exp_data, rsp_data);
                mon_errors++;
            end
            if (rsp_err !== exp_err) begin
                $display("ERROR test %0h: rsp_err expected %b actual %b", id, exp_err, rsp_err);
                mon_errors++;
            end
            // the lone first request answers in the cycle that ends two edges after acceptance.
            if (responses == 0 && cycle_cnt != accept_edge + 1) begin
                $display("ERROR test %0h: response cycle expected %0d actual %0d",
                         id, accept_edge + 1, cycle_cnt);
                mon_errors++;
            end
            responses++;
        end
    endtask

    // outputs are sampled mid cycle, well away from the edges.
    always @(negedge clk) begin
        if (!rst) begin
            if (!any_pushed && (rsp_valid || credit_return)) begin
                $display("response or credit seen before any request, cycle %0d", cycle_cnt);
                mon_errors++;
            end
            if (credit_return) begin
                credits_back++;
                if (credits_back > pushes) begin
                    $display("more credits returned than requests sent, cycle %0d", cycle_cnt);
                    mon_errors++;
                end
            end
            if (rsp_valid) check_response();
        end
    end

    task automatic wait_credit(output bit ok);
        int waited;
        waited = 0;
        while (credits_left() == 0 && waited < MAX_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        ok = (credits_left() > 0);
        if (!ok) begin
            $display("timed out waiting for a credit");
            drv_errors++;
        end
    endtask

    // presents one vector for a single cycle and records its expected response.
    task automatic send_request(input int idx);
        int base;
        base      = idx * FIELDS;
        req_valid = 1'b1;
        req_op    = mem_op_t'(vec_mem[base+1][3:0]);
        req_addr  = vec_mem[base+2][ADDR_WIDTH+1:0];
        req_wdata = vec_mem[base+3];
        exp_id_q.push_back(vec_mem[base]);
        exp_data_q.push_back(vec_mem[base+4]);
        exp_err_q.push_back(vec_mem[base+5][0]);
        push_edge_q.push_back(cycle_cnt + 1); // accepted at the coming edge.
        any_pushed = 1'b1;
        pushes++;
        if (credits_left() < 0) begin
            $display("credit count went negative at test %0h", vec_mem[base]);
            drv_errors++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        int gap;
        int waited;
        bit ok;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = LB;
        req_addr  = '0;
        req_wdata = '0;
        $readmemh("test/dmem_testdata.hex", vec_mem);
        if (vec_mem[(NUM_VEC-1)*FIELDS] !== 32'(NUM_VEC)) begin
            $display("test data file is missing or incomplete");
            drv_errors++;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk); // idle cycles, nothing may come out.
        #1;
        for (int idx = 0; idx < NUM_VEC && !aborted; idx++) begin
            seed = next_random(seed);
            // mostly back to back, now and then a sparse stretch.
            gap = (seed[17:16] == 2'b00) ? int'(seed[20:18]) : 0;
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #1;
            end
            wait_credit(ok);
            if (ok) send_request(idx);
            else aborted = 1'b1;
        end
        if (!aborted) begin
            waited = 0;
            while ((exp_id_q.size() != 0 || credits_left() != QUEUE_DEPTH) && waited < MAX_WAIT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (exp_id_q.size() != 0 || credits_left() != QUEUE_DEPTH) begin
                $display("timed out waiting for the last responses and credits");
                drv_errors++;
            end
        end
        if (credits_back != pushes) begin
            $display("ERROR test credits: returned expected %0d actual %0d", pushes, credits_back);
            drv_errors++;
        end
        $display("checks %0d, errors %0d", checks, drv_errors + mon_errors);
        if (drv_errors + mon_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dmem_subsys.f ====
src/dmem_pkg.sv
src/dmem_req_if.sv
src/req_queue.sv
src/access_align.sv
src/bram.sv
src/load_extract.sv
src/dmem_subsys.sv
test/dmem_subsys_chk.sv
test/tb_dmem_subsys.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_dmem_subsys \
		-f dmem_subsys.f -Mdir obj_dir -o tb_dmem_subsys
	@out="$$(./obj_dir/tb_dmem_subsys)"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== test/dmem_testdata.hex ====
// columns: test id, op, byte address, store data, expected rsp_data, expected rsp_err
// op codes: 0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU, 8 SB, 9 SH, a SW
01 a 010 12345678 00000000 0
02 2 010 00000000 12345678 0
03 a 020 aabbccdd 00000000 0
04 8 021 00000011 00000000 0
05 9 022 00003344 00000000 0
06 2 020 00000000 334411dd 0
07 a 030 f1e2d3c4 00000000 0
08 0 030 00000000 ffffffc4 0
09 0 031 00000000 ffffffd3 0
0a 0 032 00000000 ffffffe2 0
0b 0 033 00000000 fffffff1 0
0c 4 030 00000000 000000c4 0
0d 4 031 00000000 000000d3 0
0e 4 032 00000000 000000e2 0
0f 4 033 00000000 000000f1 0
10 1 030 00000000 ffffd3c4 0
11 1 032 00000000 fffff1e2 0
12 5 030 00000000 0000d3c4 0
13 5 032 00000000 0000f1e2 0
14 a 040 55667788 00000000 0
15 9 041 0000abcd 00000000 1
16 a 042 deadbeef 00000000 1
17 1 043 00000000 00000000 1
18 2 041 00000000 00000000 1
19 2 040 00000000 55667788 0
